// ==== pool_embed.sv ====
// Spike pooling and patch embedding stage
// OR-pools neighbouring lanes per time step, adds the even-lane shortcut
// spike and counts outputs to flag the last one of every frame.

module pool_embed (
    input  logic                      s_clk,
    input  logic                      s_rst,

    input  logic                      i_spike_valid,
    input  snn_patch_pkg::spike_map_t  i_spikes,

    output logic                      o_embed_valid,
    output snn_patch_pkg::embed_map_t  o_embed,
    output logic                      o_frame_done
);

    snn_patch_pkg::embed_map_t embed_next;

    logic [snn_patch_pkg::FRAME_CNT_WIDTH-1:0] frame_cnt;
    logic                                      frame_last;

    // Feature map plus shortcut for one output lane
    function automatic logic [snn_patch_pkg::TIME_STEPS-1:0][snn_patch_pkg::EMBED_WIDTH-1:0]
        embed_lane(
            input logic [snn_patch_pkg::TIME_STEPS-1:0] spk_even,
            input logic [snn_patch_pkg::TIME_STEPS-1:0] spk_odd
        );
        logic [snn_patch_pkg::TIME_STEPS-1:0]                           pooled;
        logic [snn_patch_pkg::TIME_STEPS-1:0][snn_patch_pkg::EMBED_WIDTH-1:0] val;
        // Max of two binary spikes is their OR
        pooled = spk_even | spk_odd;
        for (int t = 0; t < snn_patch_pkg::TIME_STEPS; t++) begin
            val[t] = snn_patch_pkg::EMBED_WIDTH'(pooled[t])
                   + snn_patch_pkg::EMBED_WIDTH'(spk_even[t]);
        end
        return val;
    endfunction

    always_comb begin
        for (int k = 0; k < snn_patch_pkg::POOL_LANES; k++) begin
            embed_next.lane[k] = embed_lane(i_spikes.lane[2*k], i_spikes.lane[2*k+1]);
        end
    end

    assign frame_last = (frame_cnt ==
                         snn_patch_pkg::FRAME_CNT_WIDTH'(snn_patch_pkg::FRAME_LEN - 1));

    // Counts accepted spike maps, wraps at the end of each frame
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            frame_cnt <= '0;
        end else if (i_spike_valid) begin
            if (frame_last) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // Done pulse is registered with the strobe so both leave on the same cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_embed_valid <= 1'b0;
            o_frame_done  <= 1'b0;
        end else begin
            o_embed_valid <= i_spike_valid;
            o_frame_done  <= i_spike_valid & frame_last;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_spike_valid) begin
            o_embed <= embed_next;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the spike patch testbench with Verilator.
# Exit status is nonzero when the build fails, the simulator
# stops with an error, or the log reports a failing run.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
BIN=sim_snn_patch

verilator --binary --timing --assert \
    --top-module tb_snn_patch \
    -Mdir "$OBJ_DIR" -o "$BIN" \
    -f snn_patch.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== snn_patch.f ====
snn_patch_pkg.sv
spike_encoder.sv
pool_embed.sv
snn_patch_top.sv
snn_patch_checker.sv
snn_patch_monitor.sv
tb_snn_patch.sv

// ==== snn_patch_checker.sv ====
// Protocol assertions for the spike patch pipeline
// Bound into snn_patch_top to watch the strobe timing and value range

module snn_patch_checker (
    input  logic                      s_clk,
    input  logic                      s_rst,
    input  logic                      i_pix_valid,
    input  logic                      o_embed_valid,
    input  logic                      o_frame_done,
    input  snn_patch_pkg::embed_map_t  o_embed
);

    logic embed_in_range;

    // Feature map plus shortcut never exceeds 2
    always_comb begin
        embed_in_range = 1'b1;
        for (int k = 0; k < snn_patch_pkg::POOL_LANES; k++) begin
            for (int t = 0; t < snn_patch_pkg::TIME_STEPS; t++) begin
                if (o_embed.lane[k][t] > 2'd2) begin
                    embed_in_range = 1'b0;
                end
            end
        end
    end

    a_valid_latency : assert property (
        @(posedge s_clk) disable iff (s_rst)
        o_embed_valid |-> $past(i_pix_valid, 2)
    ) else $error("o_embed_valid without an input sample two cycles earlier");

    a_frame_with_valid : assert property (
        @(posedge s_clk) disable iff (s_rst)
        o_frame_done |-> o_embed_valid
    ) else $error("o_frame_done raised without o_embed_valid");

    a_embed_range : assert property (
        @(posedge s_clk) disable iff (s_rst)
        o_embed_valid |-> embed_in_range
    ) else $error("embedded value above 2 in o_embed %h", o_embed);

endmodule

bind snn_patch_top snn_patch_checker u_checker (
    .s_clk          ( s_clk         ),
    .s_rst          ( s_rst         ),
    .i_pix_valid    ( i_pix_valid   ),
    .o_embed_valid  ( o_embed_valid ),
    .o_frame_done   ( o_frame_done  ),
    .o_embed        ( o_embed       )
);

// ==== snn_patch_monitor.sv ====
// Scoreboard for the spike patch pipeline
// Queues every accepted sample, predicts its embedding from the encoding
// and pooling rules and compares it with the DUT output in order.

module snn_patch_monitor (
    input  logic                      s_clk,
    input  logic                      s_rst,
    input  logic                      i_pix_valid,
    input  snn_patch_pkg::pix_sample_t i_pix,
    input  logic                      o_embed_valid,
    input  snn_patch_pkg::embed_map_t  o_embed,
    input  logic                      o_frame_done,

    output int                        o_checks,
    output int                        o_errors,
    output int                        o_outputs,
    output int                        o_frames,
    output int                        o_pending
);

    localparam int LATENCY = 2;

    snn_patch_pkg::embed_map_t exp_q[$];
    int                        stamp_q[$];

    int cycle   = 0;
    int checks  = 0;
    int errors  = 0;
    int outputs = 0;
    int frames  = 0;

    assign o_checks  = checks;
    assign o_errors  = errors;
    assign o_outputs = outputs;
    assign o_frames  = frames;
    assign o_pending = exp_q.size();

    // Reference model of encoder, pooling and shortcut add
    function automatic snn_patch_pkg::embed_map_t predict(
        input snn_patch_pkg::pix_sample_t pix
    );
        int                        mem;
        int                        even_spk;
        int                        odd_spk;
        int                        value;
        logic [snn_patch_pkg::PIX_LANES-1:0][snn_patch_pkg::TIME_STEPS-1:0] spk;
        snn_patch_pkg::embed_map_t res;
        spk = '0;
        for (int k = 0; k < snn_patch_pkg::PIX_LANES; k++) begin
            mem = 0;
            for (int t = 0; t < snn_patch_pkg::TIME_STEPS; t++) begin
                mem = mem + int'(pix.lane[k]);
                if (mem >= snn_patch_pkg::SPIKE_THRESH) begin
                    spk[k][t] = 1'b1;
                    mem = mem - snn_patch_pkg::SPIKE_THRESH;
                end
            end
        end
        for (int k = 0; k < snn_patch_pkg::POOL_LANES; k++) begin
            for (int t = 0; t < snn_patch_pkg::TIME_STEPS; t++) begin
                even_spk = int'(spk[2*k][t]);
                odd_spk  = int'(spk[2*k+1][t]);
                // Max pool, then the even lane as shortcut
                value = ((even_spk > odd_spk) ? even_spk : odd_spk) + even_spk;
                res.lane[k][t] = 2'(value);
            end
        end
        return res;
    endfunction

    always @(posedge s_clk) begin : watch
        snn_patch_pkg::embed_map_t exp;
        int                        stamp;
        logic                      exp_frame;
        cycle = cycle + 1;
        if (s_rst) begin
            if (o_embed_valid || o_frame_done) begin
                errors = errors + 1;
                $display("output strobe active during reset at cycle %0d", cycle);
            end
        end else begin
            if (o_embed_valid) begin
                if (exp_q.size() == 0) begin
                    errors = errors + 1;
                    $display("output appeared with no pending input at cycle %0d", cycle);
                end else begin
                    exp   = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    checks = checks + 1;
                    if (o_embed !== exp) begin
                        errors = errors + 1;
                        $display("ERR o_embed exp %h got %h at cycle %0d", exp, o_embed, cycle);
                    end
                    if (cycle - stamp != LATENCY) begin
                        errors = errors + 1;
                        $display("output came %0d cycles after its input instead of %0d",
                                 cycle - stamp, LATENCY);
                    end
                end
                exp_frame = ((outputs % snn_patch_pkg::FRAME_LEN) == snn_patch_pkg::FRAME_LEN - 1);
                if (o_frame_done !== exp_frame) begin
                    errors = errors + 1;
                    $display("ERR o_frame_done exp %h got %h at output %0d",
                             exp_frame, o_frame_done, outputs);
                end
                if (o_frame_done) begin
                    frames = frames + 1;
                end
                outputs = outputs + 1;
            end else if (o_frame_done) begin
                errors = errors + 1;
                $display("frame done pulse without an output at cycle %0d", cycle);
            end
            if (i_pix_valid) begin
                exp_q.push_back(predict(i_pix));
                stamp_q.push_back(cycle);
            end
        end
    end

endmodule

// ==== snn_patch_pkg.sv ====
// Shared definitions for the spike patch pipeline
// Pixel and spike widths, encoder threshold, frame length and the
// packed structs that carry samples between the stages

package snn_patch_pkg;

    // Pixel sample geometry
    localparam int PIX_WIDTH  = 8;
    localparam int PIX_LANES  = 8;
    localparam int POOL_LANES = PIX_LANES / 2;

    // Spike encoding
    localparam int TIME_STEPS   = 4;
    localparam int SPIKE_THRESH = 128;
    // Worst case is a full pixel on top of a sub-threshold remainder
    localparam int MEM_WIDTH    = 10;

    // Embedding output, values 0 to 2
    localparam int EMBED_WIDTH = 2;

    // Framing
    localparam int FRAME_LEN       = 16;
    localparam int FRAME_CNT_WIDTH = $clog2(FRAME_LEN);

    // One input sample, lane 0 in the low byte
    typedef struct packed {
        logic [PIX_LANES-1:0][PIX_WIDTH-1:0] lane;
    } pix_sample_t;

    // Encoder output, one spike bit per lane and time step
    typedef struct packed {
        logic [PIX_LANES-1:0][TIME_STEPS-1:0] lane;
    } spike_map_t;

    // Embedding output, one small value per pooled lane and time step
    typedef struct packed {
        logic [POOL_LANES-1:0][TIME_STEPS-1:0][EMBED_WIDTH-1:0] lane;
    } embed_map_t;

endpackage

// ==== snn_patch_top.sv ====
// Spike patch embedding pipeline
// Encoder stage followed by pooling and embedding, two cycles end to end.
// Accepts a new sample on any cycle with no back-pressure.

module snn_patch_top (
    input  logic                      s_clk,
    input  logic                      s_rst,

    input  logic                      i_pix_valid,
    input  snn_patch_pkg::pix_sample_t i_pix,

    output logic                      o_embed_valid,
    output snn_patch_pkg::embed_map_t  o_embed,
    output logic                      o_frame_done
);

    // Encoder to pooling stage
    logic                     spike_valid;
    snn_patch_pkg::spike_map_t spikes;

    spike_encoder u_spike_encoder (
        .s_clk          ( s_clk         ),
        .s_rst          ( s_rst         ),

        .i_pix_valid    ( i_pix_valid   ),
        .i_pix          ( i_pix         ),

        .o_spike_valid  ( spike_valid   ),
        .o_spikes       ( spikes        )
    );

    pool_embed u_pool_embed (
        .s_clk          ( s_clk         ),
        .s_rst          ( s_rst         ),

        .i_spike_valid  ( spike_valid   ),
        .i_spikes       ( spikes        ),

        .o_embed_valid  ( o_embed_valid ),
        .o_embed        ( o_embed       ),
        .o_frame_done   ( o_frame_done  )
    );

endmodule

// ==== spike_encoder.sv ====
// Integrate-and-fire spike encoder
// Turns every pixel of a sample into TIME_STEPS spikes in one cycle.
// All lanes run in parallel and each sample starts from a clean membrane.

module spike_encoder (
    input  logic                      s_clk,
    input  logic                      s_rst,

    input  logic                      i_pix_valid,
    input  snn_patch_pkg::pix_sample_t i_pix,

    output logic                      o_spike_valid,
    output snn_patch_pkg::spike_map_t  o_spikes
);

    snn_patch_pkg::spike_map_t spikes_next;

    // Integrate one pixel over all time steps and fire against the threshold
    function automatic logic [snn_patch_pkg::TIME_STEPS-1:0] fire_pixel(
        input logic [snn_patch_pkg::PIX_WIDTH-1:0] pix
    );
        logic [snn_patch_pkg::MEM_WIDTH-1:0]  mem;
        logic [snn_patch_pkg::TIME_STEPS-1:0] spk;
        mem = '0;
        spk = '0;
        for (int t = 0; t < snn_patch_pkg::TIME_STEPS; t++) begin
            mem = mem + snn_patch_pkg::MEM_WIDTH'(pix);
            if (mem >= snn_patch_pkg::MEM_WIDTH'(snn_patch_pkg::SPIKE_THRESH)) begin
                spk[t] = 1'b1;
                // Soft reset keeps the remainder for the next step
                mem = mem - snn_patch_pkg::MEM_WIDTH'(snn_patch_pkg::SPIKE_THRESH);
            end
        end
        return spk;
    endfunction

    always_comb begin
        for (int k = 0; k < snn_patch_pkg::PIX_LANES; k++) begin
            spikes_next.lane[k] = fire_pixel(i_pix.lane[k]);
        end
    end

    // Strobe follows the input by one cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_spike_valid <= 1'b0;
        end else begin
            o_spike_valid <= i_pix_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_pix_valid) begin
            o_spikes <= spikes_next;
        end
    end

endmodule

// ==== tb_snn_patch.sv ====
// Testbench for the spike patch pipeline
// Drives reset, zero and full pixels and seeded random traffic,
// then checks the frame count and reports the result

module tb_snn_patch;

    localparam int CLK_HALF       = 10;
    localparam int DRIVE_DLY      = 2;
    localparam int RESET_CYCLES   = 8;
    localparam int QUIET_CYCLES   = 5;
    localparam int EDGE_SAMPLES   = 4;
    localparam int B2B_SAMPLES    = 200;
    localparam int GAP_SAMPLES    = 150;
    localparam int MAX_GAP        = 2;
    localparam int TOTAL_SAMPLES  = 2 * EDGE_SAMPLES + B2B_SAMPLES + GAP_SAMPLES;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_SAMPLES + 100;

    logic                      s_clk = 1'b0;
    logic                      s_rst;
    logic                      i_pix_valid;
    snn_patch_pkg::pix_sample_t i_pix;
    logic                      o_embed_valid;
    snn_patch_pkg::embed_map_t  o_embed;
    logic                      o_frame_done;

    int mon_checks;
    int mon_errors;
    int mon_outputs;
    int mon_frames;
    int mon_pending;
    int tb_errors  = 0;
    int run_cycles = 0;

    always #CLK_HALF s_clk = ~s_clk;

    snn_patch_top DUT (
        .s_clk          ( s_clk         ),
        .s_rst          ( s_rst         ),
        .i_pix_valid    ( i_pix_valid   ),
        .i_pix          ( i_pix         ),
        .o_embed_valid  ( o_embed_valid ),
        .o_embed        ( o_embed       ),
        .o_frame_done   ( o_frame_done  )
    );

    snn_patch_monitor u_monitor (
        .s_clk          ( s_clk         ),
        .s_rst          ( s_rst         ),
        .i_pix_valid    ( i_pix_valid   ),
        .i_pix          ( i_pix         ),
        .o_embed_valid  ( o_embed_valid ),
        .o_embed        ( o_embed       ),
        .o_frame_done   ( o_frame_done  ),
        .o_checks       ( mon_checks    ),
        .o_errors       ( mon_errors    ),
        .o_outputs      ( mon_outputs   ),
        .o_frames       ( mon_frames    ),
        .o_pending      ( mon_pending   )
    );

    always @(posedge s_clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, %0d samples still pending",
                     run_cycles, mon_pending);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic send_sample(input snn_patch_pkg::pix_sample_t pix);
        @(posedge s_clk);
        #DRIVE_DLY;
        i_pix_valid = 1'b1;
        i_pix       = pix;
    endtask

    task automatic idle_cycle();
        @(posedge s_clk);
        #DRIVE_DLY;
        i_pix_valid = 1'b0;
    endtask

    // Wait until every sent sample has come out and let the pipeline settle
    task automatic drain();
        idle_cycle();
        while (mon_pending != 0) begin
            idle_cycle();
        end
        repeat (2) idle_cycle();
    endtask

    task automatic report_test(input string name, input int err_before);
        int errs;
        errs = mon_errors + tb_errors - err_before;
        $display("test %-20s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin : stimulus
        int                        mark;
        int                        gap;
        int                        total_errors;
        snn_patch_pkg::pix_sample_t pix;
        s_rst       = 1'b1;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        void'($urandom(32'he4ea));

        // Quiet outputs are watched from the first reset cycle on
        mark = mon_errors + tb_errors;
        repeat (RESET_CYCLES) @(posedge s_clk);
        #DRIVE_DLY;
        s_rst = 1'b0;

        repeat (QUIET_CYCLES) idle_cycle();
        if (mon_outputs != 0) begin
            tb_errors = tb_errors + 1;
            $display("outputs appeared after reset with no input");
        end
        report_test("reset_quiet", mark);

        mark = mon_errors + tb_errors;
        repeat (EDGE_SAMPLES) send_sample('0);
        repeat (EDGE_SAMPLES) send_sample('1);
        drain();
        report_test("zero_and_full", mark);

        mark = mon_errors + tb_errors;
        repeat (B2B_SAMPLES) begin
            pix = {$urandom(), $urandom()};
            send_sample(pix);
        end
        drain();
        report_test("random_back_to_back", mark);

        mark = mon_errors + tb_errors;
        repeat (GAP_SAMPLES) begin
            pix = {$urandom(), $urandom()};
            send_sample(pix);
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) idle_cycle();
        end
        drain();
        report_test("random_with_gaps", mark);

        mark = mon_errors + tb_errors;
        if (mon_outputs != TOTAL_SAMPLES) begin
            tb_errors = tb_errors + 1;
            $display("ERR o_embed_valid count exp %h got %h", TOTAL_SAMPLES, mon_outputs);
        end
        if (mon_frames != TOTAL_SAMPLES / snn_patch_pkg::FRAME_LEN) begin
            tb_errors = tb_errors + 1;
            $display("ERR o_frame_done count exp %h got %h",
                     TOTAL_SAMPLES / snn_patch_pkg::FRAME_LEN, mon_frames);
        end
        report_test("frame_marking", mark);

        total_errors = mon_errors + tb_errors;
        $display("summary: %0d outputs checked, %0d errors", mon_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
